// ==== sdram_config.svh ====
// timing, refresh, address width and init wait constants for the sdram controller
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

`define SDRAM_CL         2    // cas latency
`define SDRAM_TRCD       2    // activate to read/write
`define SDRAM_TRP        2    // precharge to activate
`define SDRAM_TRFC       7    // refresh to next command
`define SDRAM_RFSHCNT    4    // refresh commands per rfsh pulse

// power-up wait, short for simulation
`define SDRAM_INIT_WAIT  100

`define SDRAM_AW         22   // bank word address
`define SDRAM_ROW_W      13
`define SDRAM_COL_W      9
`define SDRAM_BURST      4    // read burst, 64 bits

`endif

// ==== sdram_cmd_pkg.sv ====
// sdram command encoding, address pin union and per-source command word
`include "sdram_config.svh"

package sdram_cmd_pkg;

    // bits are /cs /ras /cas /we
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } sdram_cmd_e;

    // column view of the a pins
    typedef struct packed {
        logic [1:0]              spare_hi;
        logic                    a10;      // auto precharge, or all banks on precharge
        logic                    spare;
        logic [`SDRAM_COL_W-1:0] col;
    } sdram_col_t;

    // the same 13 pins read as a row or as a column word
    typedef union packed {
        logic [`SDRAM_ROW_W-1:0] row;
        sdram_col_t              col;
    } sdram_addr_u;

    typedef struct packed {
        sdram_cmd_e  cmd;
        logic [1:0]  ba;
        sdram_addr_u a;
    } sdram_pins_t;

    // idle word, what a source drives when it has nothing to say
    localparam sdram_pins_t PINS_NOP = {CMD_NOP, 2'b00, 13'd0};

endpackage

// ==== sdram_req_pkg.sv ====
// bank request and bank status structs
`include "sdram_config.svh"

package sdram_req_pkg;

    // one port request, held by the user until ack
    typedef struct packed {
        logic [`SDRAM_AW-1:0] addr;
        logic                 rd;
        logic                 wr;
    } bank_req_t;

    // bank state seen by the scheduler
    typedef struct packed {
        logic br;      // next command may issue now
        logic dbusy;   // data burst or write in flight
        logic gap;     // waiting out trp or trcd
    } bank_stat_t;

endpackage

// ==== sdram_init.sv ====
// power-up sequencer: wait, precharge all, two refreshes, load mode
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_init
    import sdram_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    output logic        init_busy,
    output sdram_pins_t pins
);
    localparam int T_PRE  = `SDRAM_INIT_WAIT;
    localparam int T_REF1 = T_PRE + `SDRAM_TRP;
    localparam int T_REF2 = T_REF1 + `SDRAM_TRFC;
    localparam int T_LMR  = T_REF2 + `SDRAM_TRFC;
    localparam int T_END  = T_LMR + 2;               // tmrd

    logic [15:0] cnt;

    assign init_busy = cnt != 16'(T_END);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (init_busy) begin
            cnt <= cnt + 16'd1;
        end
    end

    always_comb begin
        pins = PINS_NOP;
        if (cnt == 16'(T_PRE)) begin
            pins.cmd       = CMD_PRECHARGE;
            pins.a.col.a10 = 1'b1;                   // all banks
        end else if (cnt == 16'(T_REF1) || cnt == 16'(T_REF2)) begin
            pins.cmd = CMD_REFRESH;
        end else if (cnt == 16'(T_LMR)) begin
            pins.cmd = CMD_LOAD_MODE;
            // single-word writes, cas latency, sequential, burst length
            pins.a.row = {3'b000, 1'b1, 2'b00, 3'(`SDRAM_CL), 1'b0, 3'($clog2(`SDRAM_BURST))};
        end
    end

endmodule

// ==== sdram_rfsh.sv ====
// refresh engine: precharge all, then a spaced run of refresh commands
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_rfsh
    import sdram_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        gnt,
    output logic        req,
    output logic        rfshing,
    output sdram_pins_t pins
);
    localparam int PW = $clog2(`SDRAM_RFSHCNT + 1);

    logic [PW-1:0] pend;     // refreshes still to issue
    logic [3:0]    wcnt;     // cycles to next command
    logic          pre;      // precharge all not yet issued

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req     <= 1'b0;
            rfshing <= 1'b0;
            pre     <= 1'b0;
            pend    <= '0;
            wcnt    <= '0;
        end else begin
            if (start && !rfshing) begin
                req  <= 1'b1;
                pend <= PW'(`SDRAM_RFSHCNT);
            end
            if (gnt) begin
                req     <= 1'b0;
                rfshing <= 1'b1;
                pre     <= 1'b1;
                wcnt    <= '0;
            end else if (rfshing) begin
                if (wcnt != 0) begin
                    wcnt <= wcnt - 4'd1;
                end else if (pre) begin
                    pre  <= 1'b0;
                    wcnt <= 4'(`SDRAM_TRP - 1);
                end else if (pend != 0) begin
                    pend <= pend - PW'(1);
                    wcnt <= 4'(`SDRAM_TRFC - 1);
                end else begin
                    rfshing <= 1'b0;             // last trfc done
                end
            end
        end
    end

    always_comb begin
        pins = PINS_NOP;
        if (rfshing && wcnt == 0) begin
            if (pre) begin
                pins.cmd       = CMD_PRECHARGE;
                pins.a.col.a10 = 1'b1;
            end else if (pend != 0) begin
                pins.cmd = CMD_REFRESH;
            end
        end
    end

endmodule

// ==== sdram_bank.sv ====
// bank engine: open row tracking, precharge/activate/read/write sequencing, data framing
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_bank
    import sdram_cmd_pkg::*, sdram_req_pkg::*;
#(
    parameter logic [1:0] BANK = 2'd0
) (
    input  logic        clk,
    input  logic        rst,
    input  bank_req_t   req,
    input  logic        bg,
    input  logic        prech_all,
    input  logic        other_dbusy,
    output logic        ack,
    output logic        dst,
    output logic        dok,
    output logic        rdy,
    output bank_stat_t  stat,
    output sdram_pins_t pins
);
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRE,
        ST_ACT,
        ST_GAP,
        ST_COL
    } state_e;

    // ack cycle to one past rdy: command reg, cl, dout capture, burst
    localparam int RD_LEN = `SDRAM_CL + 2 + `SDRAM_BURST;

    state_e                  st;
    state_e                  gap_next;
    logic [`SDRAM_ROW_W-1:0] row;
    logic [`SDRAM_ROW_W-1:0] open_row;
    logic [`SDRAM_COL_W-1:0] col;
    logic                    row_ok;
    logic [2:0]              gap_cnt;
    logic [3:0]              dcnt;
    logic                    is_rd;

    assign row = req.addr[`SDRAM_AW-1 -: `SDRAM_ROW_W];
    assign col = req.addr[`SDRAM_COL_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= ST_IDLE;
            gap_next <= ST_IDLE;
            row_ok   <= 1'b0;
            gap_cnt  <= '0;
            dcnt     <= '0;
            is_rd    <= 1'b0;
            ack      <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (dcnt != 0) dcnt <= dcnt - 4'd1;
            if (prech_all) row_ok <= 1'b0;       // refresh closes every row
            case (st)
                ST_IDLE: begin
                    if (dcnt == 0 && (req.rd || req.wr)) begin
                        if (!row_ok) st <= ST_ACT;
                        else if (open_row == row) st <= ST_COL;   // row hit
                        else st <= ST_PRE;                       // row miss
                    end
                end
                ST_PRE: begin
                    if (bg) begin
                        row_ok   <= 1'b0;
                        gap_cnt  <= 3'(`SDRAM_TRP - 2);
                        gap_next <= ST_ACT;
                        st       <= ST_GAP;
                    end
                end
                ST_ACT: begin
                    if (bg) begin
                        row_ok   <= 1'b1;
                        gap_cnt  <= 3'(`SDRAM_TRCD - 2);
                        gap_next <= ST_COL;
                        st       <= ST_GAP;
                    end
                end
                ST_GAP: begin
                    if (gap_cnt == 0) st <= gap_next;
                    else gap_cnt <= gap_cnt - 3'd1;
                end
                ST_COL: begin
                    if (bg) begin
                        ack   <= 1'b1;               // command shows on the pins now
                        is_rd <= !req.wr;
                        dcnt  <= req.wr ? 4'd2 : 4'(RD_LEN);
                        st    <= ST_IDLE;
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == ST_ACT && bg) open_row <= row;
    end

    // reads wait for any other burst to leave dq
    assign stat.br    = st == ST_PRE || st == ST_ACT || (st == ST_COL && !other_dbusy);
    assign stat.dbusy = dcnt != 0;
    assign stat.gap   = st == ST_GAP;

    assign dst = is_rd && dcnt == 4'(`SDRAM_BURST);
    assign dok = is_rd && dcnt != 0 && dcnt <= 4'(`SDRAM_BURST);
    assign rdy = dcnt == 4'd1;                  // last word, or write done

    always_comb begin
        pins    = PINS_NOP;
        pins.ba = BANK;
        case (st)
            ST_PRE: pins.cmd = CMD_PRECHARGE;    // a10 low, this bank only
            ST_ACT: begin
                pins.cmd   = CMD_ACTIVE;
                pins.a.row = row;
            end
            ST_COL: begin
                pins.cmd = req.wr ? CMD_WRITE : CMD_READ;
                // bursts start on a four-word boundary
                pins.a.col.col = req.wr ? col : {col[`SDRAM_COL_W-1:2], 2'b00};
            end
            default: pins.cmd = CMD_NOP;
        endcase
    end

endmodule

// ==== sdram_sched.sv ====
// command scheduler: arbitration, command mux, pin registers and read capture
`timescale 1ns/1ps

module sdram_sched
    import sdram_cmd_pkg::*, sdram_req_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  sdram_pins_t [3:0] bank_pins,
    input  bank_stat_t  [3:0] bank_stat,
    input  logic [3:0]        pending,     // rd | wr per port
    input  logic              init_busy,
    input  logic              rfshing,
    input  logic              rfsh_req,
    input  sdram_pins_t       init_pins,
    input  sdram_pins_t       rfsh_pins,
    output logic [3:0]        bg,
    output logic              rfsh_gnt,
    output logic              prech_all,
    output logic [3:0]        other_dbusy,
    input  logic [15:0]       din,
    input  logic [1:0]        din_m,
    output logic [15:0]       dout,
    inout  wire  [15:0]       sdram_dq,
    output logic [12:0]       sdram_a,
    output logic [1:0]        sdram_ba,
    output logic              sdram_ncs,
    output logic              sdram_nras,
    output logic              sdram_ncas,
    output logic              sdram_nwe,
    output logic              sdram_dqml,
    output logic              sdram_dqmh,
    output logic              sdram_cke
);
    logic [14:0] lfsr;
    logic [3:0]  br;
    logic [3:0]  dbusy;
    logic [3:0]  gap;
    sdram_pins_t next_pins;
    sdram_pins_t pins_q;
    logic        wr_cyc;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            br[i]          = bank_stat[i].br;
            dbusy[i]       = bank_stat[i].dbusy;
            gap[i]         = bank_stat[i].gap;
            other_dbusy[i] = |(dbusy & ~(4'b0001 << i));
        end
    end

    // scan upward from the lfsr pick, first requester wins
    always_comb begin
        logic [1:0] idx;
        logic       found;
        bg    = '0;
        found = 1'b0;
        idx   = lfsr[1:0];
        if (!init_busy && !rfshing) begin
            for (int k = 0; k < 4; k++) begin
                if (br[idx] && !found) begin
                    bg[idx] = 1'b1;
                    found   = 1'b1;
                end
                idx = idx + 2'd1;
            end
        end
    end

    // refresh only on a fully quiet bus
    assign rfsh_gnt  = rfsh_req && !init_busy && !rfshing && br == 4'd0 && dbusy == 4'd0
                       && gap == 4'd0 && pending == 4'd0;
    assign prech_all = rfsh_gnt;

    always_comb begin
        next_pins = PINS_NOP;
        if (init_busy) begin
            next_pins = init_pins;
        end else if (rfshing) begin
            next_pins = rfsh_pins;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (bg[i]) next_pins = bank_pins[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr   <= 15'd1;
            pins_q <= PINS_NOP;
        end else begin
            lfsr   <= {lfsr[0] ^ lfsr[14], lfsr[14:1]};
            pins_q <= next_pins;
        end
    end

    always_ff @(posedge clk) begin
        dout <= sdram_dq;                        // banks frame it with dok
    end

    assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = pins_q.cmd;
    assign sdram_ba  = pins_q.ba;
    assign sdram_a   = pins_q.a;
    assign sdram_cke = 1'b1;

    // write data and byte mask only in the write command cycle
    assign wr_cyc                   = pins_q.cmd == CMD_WRITE;
    assign sdram_dq                 = wr_cyc ? din : 16'hzzzz;
    assign {sdram_dqmh, sdram_dqml} = wr_cyc ? din_m : 2'b00;

endmodule

// ==== sdram_ctrl.sv ====
// sdram controller top: scheduler, init, refresh and four bank engines
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_ctrl
    import sdram_cmd_pkg::*, sdram_req_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic [3:0][`SDRAM_AW-1:0]     ba_addr,
    input  logic [3:0]                    rd,
    input  logic [3:0]                    wr,
    input  logic [15:0]                   din,
    input  logic [1:0]                    din_m,    // byte mask, high skips the byte
    input  logic                          rfsh,
    output logic [3:0]                    ack,
    output logic [3:0]                    dst,
    output logic [3:0]                    dok,
    output logic [3:0]                    rdy,
    output logic [15:0]                   dout,
    inout  wire  [15:0]                   sdram_dq,
    output logic [12:0]                   sdram_a,
    output logic [1:0]                    sdram_ba,
    output logic                          sdram_ncs,
    output logic                          sdram_nras,
    output logic                          sdram_ncas,
    output logic                          sdram_nwe,
    output logic                          sdram_dqml,
    output logic                          sdram_dqmh,
    output logic                          sdram_cke
);
    sdram_pins_t [3:0] bank_pins;
    bank_stat_t  [3:0] bank_stat;
    sdram_pins_t       init_pins;
    sdram_pins_t       rfsh_pins;
    logic [3:0]        bg;
    logic [3:0]        other_dbusy;
    logic [3:0]        pending;
    logic              init_busy;
    logic              rfshing;
    logic              rfsh_req;
    logic              rfsh_gnt;
    logic              prech_all;

    assign pending = rd | wr;

    for (genvar i = 0; i < 4; i++) begin : g_bank
        bank_req_t req;
        assign req = '{addr: ba_addr[i], rd: rd[i], wr: wr[i]};

        sdram_bank #(.BANK(2'(i))) i_bank (
            .clk         (clk),
            .rst         (rst),
            .req         (req),
            .bg          (bg[i]),
            .prech_all   (prech_all),
            .other_dbusy (other_dbusy[i]),
            .ack         (ack[i]),
            .dst         (dst[i]),
            .dok         (dok[i]),
            .rdy         (rdy[i]),
            .stat        (bank_stat[i]),
            .pins        (bank_pins[i])
        );
    end

    sdram_init i_init (
        .clk       (clk),
        .rst       (rst),
        .init_busy (init_busy),
        .pins      (init_pins)
    );

    sdram_rfsh i_rfsh (
        .clk     (clk),
        .rst     (rst),
        .start   (rfsh),
        .gnt     (rfsh_gnt),
        .req     (rfsh_req),
        .rfshing (rfshing),
        .pins    (rfsh_pins)
    );

    sdram_sched i_sched (
        .clk         (clk),
        .rst         (rst),
        .bank_pins   (bank_pins),
        .bank_stat   (bank_stat),
        .pending     (pending),
        .init_busy   (init_busy),
        .rfshing     (rfshing),
        .rfsh_req    (rfsh_req),
        .init_pins   (init_pins),
        .rfsh_pins   (rfsh_pins),
        .bg          (bg),
        .rfsh_gnt    (rfsh_gnt),
        .prech_all   (prech_all),
        .other_dbusy (other_dbusy),
        .din         (din),
        .din_m       (din_m),
        .dout        (dout),
        .sdram_dq    (sdram_dq),
        .sdram_a     (sdram_a),
        .sdram_ba    (sdram_ba),
        .sdram_ncs   (sdram_ncs),
        .sdram_nras  (sdram_nras),
        .sdram_ncas  (sdram_ncas),
        .sdram_nwe   (sdram_nwe),
        .sdram_dqml  (sdram_dqml),
        .sdram_dqmh  (sdram_dqmh),
        .sdram_cke   (sdram_cke)
    );

endmodule

// ==== sdram_model.sv ====
// behavioural sdram with four banks, open rows, cas latency 2 and bursts of four
`timescale 1ns/1ps

module sdram_model (
    input  logic        clk,
    input  logic        rst,
    inout  wire  [15:0] dq,
    input  logic [12:0] a,
    input  logic [1:0]  ba,
    input  logic        ncs,
    input  logic        nras,
    input  logic        ncas,
    input  logic        nwe,
    input  logic        dqml,
    input  logic        dqmh,
    input  logic        cke,
    output logic        mode_set,
    output logic        err,
    output int          pre_all_cnt,
    output int          ref_cnt
);
    // {/cs /ras /cas /we} truth table
    localparam logic [3:0] C_LMR = 4'b0000;
    localparam logic [3:0] C_REF = 4'b0001;
    localparam logic [3:0] C_PRE = 4'b0010;
    localparam logic [3:0] C_ACT = 4'b0011;
    localparam logic [3:0] C_WR  = 4'b0100;
    localparam logic [3:0] C_RD  = 4'b0101;
    localparam logic [3:0] C_NOP = 4'b0111;

    logic [15:0] mem [logic [23:0]];     // key is {bank, row, col}
    logic [3:0]  open_b;
    logic [12:0] orow [4];
    logic [3:0]  cmd;
    logic [23:0] key;
    logic [23:0] rd_base;
    int          init_step;
    int          rd_dly;
    int          bidx;
    logic        drv_en;
    logic [15:0] drv_val;

    assign cmd = {ncs, nras, ncas, nwe};
    assign key = {ba, orow[ba], a[8:0]};
    assign dq  = drv_en ? drv_val : 16'hzzzz;

    // never-written words read back as a mix of all address bits
    function automatic logic [15:0] peek(input logic [23:0] k);
        if (mem.exists(k)) return mem[k];
        return {k[23:16] ^ k[15:8], k[7:0]};
    endfunction

    function automatic logic [3:0] init_cmd(input int step);
        case (step)
            0:       return C_PRE;
            1, 2:    return C_REF;
            default: return C_LMR;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin : seq
        logic [15:0] w;
        if (rst) begin
            mode_set    <= 1'b0;
            err         <= 1'b0;
            open_b      <= '0;
            init_step   <= 0;
            pre_all_cnt <= 0;
            ref_cnt     <= 0;
            rd_dly      <= 0;
            bidx        <= 0;
            drv_en      <= 1'b0;
        end else begin
            if (!cke) begin
                $display("sdram model: clock enable low");
                err <= 1'b1;
            end
            // word 0 of a read burst goes out two edges after the read edge
            if (rd_dly != 0) begin
                rd_dly <= rd_dly - 1;
                if (rd_dly == 1) begin
                    drv_en  <= 1'b1;
                    drv_val <= peek(rd_base);
                    bidx    <= 1;
                end
            end else if (bidx == 4) begin
                drv_en <= 1'b0;
                bidx   <= 0;
            end else if (bidx != 0) begin
                drv_val <= peek(rd_base + 24'(bidx));
                bidx    <= bidx + 1;
            end
            if (!mode_set) begin
                if (cmd != C_NOP) begin
                    if (cmd != init_cmd(init_step) || (cmd == C_PRE && !a[10])) begin
                        $display("sdram model: wrong command %b in init step %0d", cmd, init_step);
                        err <= 1'b1;
                    end
                    if (cmd == C_PRE) pre_all_cnt <= pre_all_cnt + 1;
                    if (cmd == C_REF) ref_cnt <= ref_cnt + 1;
                    if (cmd == C_LMR && init_step == 3) mode_set <= 1'b1;
                    init_step <= init_step + 1;
                end
            end else begin
                case (cmd)
                    C_NOP: ;
                    C_ACT: begin
                        if (open_b[ba]) begin
                            $display("sdram model: activate on open bank %0d", ba);
                            err <= 1'b1;
                        end
                        open_b[ba] <= 1'b1;
                        orow[ba]   <= a;
                    end
                    C_PRE: begin
                        if (a[10]) begin
                            open_b      <= '0;
                            pre_all_cnt <= pre_all_cnt + 1;
                        end else begin
                            open_b[ba] <= 1'b0;
                        end
                    end
                    C_REF: begin
                        if (open_b != 0) begin
                            $display("sdram model: refresh with a row open");
                            err <= 1'b1;
                        end
                        ref_cnt <= ref_cnt + 1;
                    end
                    C_RD: begin
                        if (!open_b[ba]) begin
                            $display("sdram model: read on closed bank %0d", ba);
                            err <= 1'b1;
                        end
                        rd_base <= {key[23:2], 2'b00};      // burst aligned to four
                        rd_dly  <= 2;
                    end
                    C_WR: begin
                        if (!open_b[ba]) begin
                            $display("sdram model: write on closed bank %0d", ba);
                            err <= 1'b1;
                        end
                        w = peek(key);
                        if (!dqml) w[7:0] = dq[7:0];
                        if (!dqmh) w[15:8] = dq[15:8];
                        mem[key] = w;
                    end
                    default: begin
                        $display("sdram model: unexpected command %b", cmd);
                        err <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// ==== tb_sdram_ctrl.sv ====
// testbench for the sdram controller with trace-driven stimulus, read framing and refresh checks
`timescale 1ns/1ps
`include "sdram_config.svh"

module tb_sdram_ctrl;
    localparam int WAIT_MAX = 400;           // cycles per wait loop

    logic                      clk;
    logic                      rst;
    logic [3:0][`SDRAM_AW-1:0] ba_addr;
    logic [3:0]                rd;
    logic [3:0]                wr;
    logic [15:0]               din;
    logic [1:0]                din_m;
    logic                      rfsh;
    logic [3:0]                ack;
    logic [3:0]                dst;
    logic [3:0]                dok;
    logic [3:0]                rdy;
    logic [15:0]               dout;
    wire  [15:0]               sdram_dq;
    logic [12:0]               sdram_a;
    logic [1:0]                sdram_ba;
    logic                      sdram_ncs;
    logic                      sdram_nras;
    logic                      sdram_ncas;
    logic                      sdram_nwe;
    logic                      sdram_dqml;
    logic                      sdram_dqmh;
    logic                      sdram_cke;
    logic                      mode_set;
    logic                      model_err;
    int                        pre_all_cnt;
    int                        ref_cnt;

    // pending read group
    logic [3:0]                grp_act;
    logic [`SDRAM_AW-1:0]      grp_addr [4];
    logic [15:0]               grp_exp [4][4];

    sdram_ctrl i_sdram_ctrl (.*);

    sdram_model i_model (
        .clk(clk), .rst(rst), .dq(sdram_dq), .a(sdram_a), .ba(sdram_ba),
        .ncs(sdram_ncs), .nras(sdram_nras), .ncas(sdram_ncas), .nwe(sdram_nwe),
        .dqml(sdram_dqml), .dqmh(sdram_dqmh), .cke(sdram_cke),
        .mode_set(mode_set), .err(model_err), .pre_all_cnt(pre_all_cnt), .ref_cnt(ref_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            abort();
        end
    endtask

    task automatic timed_out(input string what);
        $display("timed out waiting for %s", what);
        abort();
    endtask

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(negedge clk) begin
        if (!rst && model_err) begin
            $display("sdram model saw an illegal command sequence");
            abort();
        end
        if (!rst && ack != 0 && !mode_set) begin
            $display("ack given before the sdram mode register was loaded");
            abort();
        end
    end

    task automatic write_word(input int p, input logic [`SDRAM_AW-1:0] addr,
                              input logic [15:0] data, input logic [1:0] mask);
        int t;
        ba_addr[p] = addr;
        din        = data;                   // held until the next write
        din_m      = mask;
        wr[p]      = 1'b1;
        t          = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > WAIT_MAX) timed_out("write ack");
        end while (!ack[p]);
        wr[p] = 1'b0;
        @(negedge clk);
        check($sformatf("rdy[%0d] after write", p), 32'(rdy[p]), 32'd1);
    endtask

    // raise every queued read at once and follow each port through its burst
    task automatic run_group();
        int         t;
        int         widx [4];
        int         ack_t [4];
        logic [3:0] busy;
        busy = grp_act;
        for (int p = 0; p < 4; p++) begin
            widx[p]  = 0;
            ack_t[p] = 0;
            if (grp_act[p]) begin
                ba_addr[p] = grp_addr[p];
                rd[p]      = 1'b1;
            end
        end
        t = 0;
        while (busy != 0) begin
            @(negedge clk);
            t++;
            if (t > WAIT_MAX) timed_out("read group to finish");
            check("dok overlap", 32'(dok & (dok - 4'd1)), 32'd0);
            for (int p = 0; p < 4; p++) begin
                if (ack[p]) begin
                    check($sformatf("rd[%0d] at ack", p), 32'(rd[p]), 32'd1);
                    rd[p]    = 1'b0;
                    ack_t[p] = t;
                end
                if (dok[p]) begin
                    check($sformatf("dok[%0d] word count", p), 32'(widx[p] < 4), 32'd1);
                    check($sformatf("dst[%0d]", p), 32'(dst[p]), 32'(widx[p] == 0));
                    if (widx[p] == 0) begin
                        check($sformatf("ack[%0d] to dst delay", p), 32'(t - ack_t[p]),
                              32'(`SDRAM_CL + 2));
                    end
                    check($sformatf("dout word %0d port %0d", widx[p], p), 32'(dout),
                          32'(grp_exp[p][widx[p]]));
                    check($sformatf("rdy[%0d]", p), 32'(rdy[p]), 32'(widx[p] == 3));
                    widx[p]++;
                    if (widx[p] == 4) busy[p] = 1'b0;
                end else begin
                    check($sformatf("dst[%0d]", p), 32'(dst[p]), 32'd0);
                    check($sformatf("rdy[%0d]", p), 32'(rdy[p]), 32'd0);
                end
            end
        end
        grp_act = '0;
        @(negedge clk);
        check("dok after burst", 32'(dok), 32'd0);
    endtask

    task automatic refresh_run();
        int pre0;
        int ref0;
        int t;
        pre0 = pre_all_cnt;
        ref0 = ref_cnt;
        rfsh = 1'b1;
        @(negedge clk);
        rfsh = 1'b0;
        t    = 0;
        while (ref_cnt < ref0 + `SDRAM_RFSHCNT) begin
            @(negedge clk);
            t++;
            if (t > WAIT_MAX) timed_out("refresh commands");
        end
        repeat (3 * `SDRAM_TRFC) @(negedge clk);   // catch any extra refresh
        check("precharge-all count", 32'(pre_all_cnt - pre0), 32'd1);
        check("refresh count", 32'(ref_cnt - ref0), 32'(`SDRAM_RFSHCNT));
    endtask

    initial begin
        int             fd;
        int             n;
        int             op;
        int             bank;
        string          line;
        logic [31:0]    rng;
        logic [`SDRAM_AW-1:0] addr;
        logic [15:0]    data;
        logic [15:0]    e0;
        logic [15:0]    e1;
        logic [15:0]    e2;
        logic [15:0]    e3;
        logic [1:0]     mask;
        rst     = 1'b1;
        rd      = '0;
        wr      = '0;
        din     = '0;
        din_m   = '0;
        rfsh    = 1'b0;
        ba_addr = '0;
        grp_act = '0;
        rng = 32'h08c7_d1e4;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        fd = $fopen("sdram_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open sdram_trace.txt");
            abort();
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        op, bank, addr, data, mask, e0, e1, e2, e3);
            if (n != 9) begin
                $display("malformed trace line: %s", line);
                abort();
            end
            rng = next_rand(rng);
            repeat (int'(rng[2:0])) @(negedge clk);
            case (op)
                0: write_word(bank, addr, data, mask);
                1, 2: begin
                    grp_act[bank]  = 1'b1;
                    grp_addr[bank] = addr;
                    grp_exp[bank]  = '{e0, e1, e2, e3};
                    if (op == 1) run_group();
                end
                3: run_group();
                4: refresh_run();
                default: begin
                    $display("unknown op code %0d in trace", op);
                    abort();
                end
            endcase
        end
        $fclose(fd);
        $display("Simulation passed");
        $finish;
    end

    initial begin
        #1ms;
        $display("run did not finish within the time limit");
        abort();
    end

endmodule

// ==== sdram_ctrl.f ====
+incdir+.
sdram_cmd_pkg.sv
sdram_req_pkg.sv
sdram_init.sv
sdram_rfsh.sv
sdram_bank.sv
sdram_sched.sv
sdram_ctrl.sv
sdram_model.sv
tb_sdram_ctrl.sv

// ==== Makefile ====
SIM    := verilator
FLAGS  := --binary --timing
TOP    := tb_sdram_ctrl
FLIST  := sdram_ctrl.f
HDRS   := sdram_config.svh
SRCS   := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN    := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== sdram_trace.txt ====
# op bank addr data mask exp0 exp1 exp2 exp3 (hex)
# op 0 write, 1 read, 2 queue read in group, 3 run group, 4 refresh pulse
0 0 000010 1111 0 0 0 0 0
0 0 000011 2222 0 0 0 0 0
0 0 000012 3333 0 0 0 0 0
0 0 000013 4444 0 0 0 0 0
1 0 000012 0 0 1111 2222 3333 4444
0 0 000011 aaaa 1 0 0 0 0
0 0 000013 bbbb 2 0 0 0 0
1 0 000010 0 0 1111 aa22 3333 44bb
0 0 001010 5555 0 0 0 0 0
1 0 000010 0 0 1111 aa22 3333 44bb
1 0 001011 0 0 5555 1011 1012 1013
2 1 000020 0 0 4020 4021 4022 4023
2 2 000104 0 0 8104 8105 8106 8107
2 3 000208 0 0 c208 c209 c20a c20b
2 0 000013 0 0 1111 aa22 3333 44bb
3 0 000000 0 0 0 0 0 0
4 0 000000 0 0 0 0 0 0
1 1 000021 0 0 4020 4021 4022 4023
1 0 000010 0 0 1111 aa22 3333 44bb
0 2 000105 9999 0 0 0 0 0
1 2 000106 0 0 8104 9999 8106 8107
